/* logic/fir_pkg.sv */
package fir_pkg;

    // sample and result width
    localparam int SAMPLE_W = 16;
    localparam int TAPS = 32;
    localparam int HALF_TAPS = TAPS / 2;
    localparam int COEF_W = 18;
    localparam int ACC_W = 40;
    // arithmetic shift applied to the full sum
    localparam int ZOOM = 16;

    // credit scheme
    localparam int IN_CREDITS = 4;
    localparam int OUT_CREDITS = 2;
    localparam int QUEUE_DEPTH = IN_CREDITS;

    // counter widths
    localparam int FILL_W = $clog2(TAPS);
    localparam int OCNT_W = $clog2(OUT_CREDITS + 1);
    localparam int QPTR_W = $clog2(QUEUE_DEPTH);

    // tap j and tap TAPS-1-j share entry j
    localparam logic signed [COEF_W-1:0] FIR_COEF [HALF_TAPS] = '{
        -18'sd120,  -18'sd211,  -18'sd318,  -18'sd397,
        -18'sd380,  -18'sd188,  18'sd256,   18'sd996,
        18'sd2018,  18'sd3249,  18'sd4580,  18'sd5868,
        18'sd6959,  18'sd7742,  18'sd8195,  18'sd8340
    };

    typedef logic signed [SAMPLE_W-1:0] sample_t;

    // index 0 holds the newest sample
    typedef sample_t [TAPS-1:0] tap_vec_t;

    typedef logic signed [ACC_W-1:0] acc_t;

    typedef logic [FILL_W-1:0] fill_cnt_t;
    typedef logic [OCNT_W-1:0] out_cnt_t;
    typedef logic [QPTR_W-1:0] qptr_t;
    typedef logic [QPTR_W:0] qcnt_t;

    typedef struct packed {
        logic    valid;
        sample_t data;
    } fir_beat_t;

    typedef enum logic {
        CTRL_FILL,
        CTRL_RUN
    } ctrl_state_e;

endpackage

/* logic/fir_tap_line.sv */
`timescale 1ns/10ps

module fir_tap_line (
    input  logic               clk,
    input  logic               rst,
    input  logic               shift_i,
    input  fir_pkg::sample_t   sample_i,
    output fir_pkg::tap_vec_t  taps_o
);

    // newest sample enters at index 0, oldest falls off the top
    always_ff @(posedge clk) begin
        if (rst) begin
            taps_o <= '0;
        end else if (shift_i) begin
            taps_o <= {taps_o[fir_pkg::TAPS-2:0], sample_i};
        end
    end

endmodule

/* logic/fir_mac.sv */
`timescale 1ns/10ps

module fir_mac (
    input  logic                clk,
    input  logic                rst,
    input  logic                valid_i,
    input  fir_pkg::tap_vec_t   taps_i,
    output fir_pkg::fir_beat_t  beat_o
);

    logic signed [fir_pkg::SAMPLE_W:0] pair_d [fir_pkg::HALF_TAPS];
    logic signed [fir_pkg::SAMPLE_W:0] pair_q [fir_pkg::HALF_TAPS];
    logic valid_q;
    fir_pkg::acc_t acc_sum;
    fir_pkg::acc_t acc_shift;
    fir_pkg::sample_t rounded;

    // fold symmetric taps, one extra bit for the pair sum
    always_comb begin
        for (int j = 0; j < fir_pkg::HALF_TAPS; j++) begin
            pair_d[j] = {taps_i[j][fir_pkg::SAMPLE_W-1], taps_i[j]}
                + {taps_i[fir_pkg::TAPS-1-j][fir_pkg::SAMPLE_W-1],
                   taps_i[fir_pkg::TAPS-1-j]};
        end
    end

    // stage 1 snapshot, tap line is free to shift again
    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= valid_i;
        end
        pair_q <= pair_d;
    end

    // products and adder tree
    always_comb begin
        acc_sum = '0;
        for (int j = 0; j < fir_pkg::HALF_TAPS; j++) begin
            acc_sum = acc_sum + fir_pkg::acc_t'(pair_q[j])
                * fir_pkg::acc_t'(fir_pkg::FIR_COEF[j]);
        end
    end

    assign acc_shift = acc_sum >>> fir_pkg::ZOOM;

    // negative sums get one added after the shift
    assign rounded = acc_shift[fir_pkg::SAMPLE_W-1:0]
        + {{(fir_pkg::SAMPLE_W-1){1'b0}}, acc_sum[fir_pkg::ACC_W-1]};

    // stage 2
    always_ff @(posedge clk) begin
        if (rst) begin
            beat_o.valid <= 1'b0;
        end else begin
            beat_o.valid <= valid_q;
        end
        beat_o.data <= rounded;
    end

endmodule

/* logic/fir_ctrl.sv */
`timescale 1ns/10ps

module fir_ctrl (
    input  logic clk,
    input  logic rst,
    input  logic in_valid_i,
    input  logic out_credit_i,
    input  logic head_valid_i,
    output logic shift_o,
    output logic mac_valid_o,
    output logic pop_o,
    output logic in_credit_o
);

    fir_pkg::ctrl_state_e state_q;
    fir_pkg::fill_cnt_t fill_cnt_q;
    fir_pkg::out_cnt_t out_credits_q;
    logic fill_credit_q;

    // source only sends while it holds a credit, so every beat is taken
    assign shift_o = in_valid_i;
    assign pop_o = head_valid_i && (out_credits_q != '0);

    // run samples free their credit when the result leaves the queue
    assign in_credit_o = pop_o || fill_credit_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= fir_pkg::CTRL_FILL;
            fill_cnt_q <= '0;
            fill_credit_q <= 1'b0;
            mac_valid_o <= 1'b0;
        end else begin
            fill_credit_q <= 1'b0;
            mac_valid_o <= 1'b0;
            if (in_valid_i) begin
                case (state_q)
                    fir_pkg::CTRL_FILL: begin
                        fill_credit_q <= 1'b1;
                        fill_cnt_q <= fill_cnt_q + 1'b1;
                        // sample TAPS-2 is the last one without a result
                        if (int'(fill_cnt_q) == fir_pkg::TAPS - 2) begin
                            state_q <= fir_pkg::CTRL_RUN;
                        end
                    end
                    default: begin
                        mac_valid_o <= 1'b1;
                    end
                endcase
            end
        end
    end

    // output credits
    always_ff @(posedge clk) begin
        if (rst) begin
            out_credits_q <= fir_pkg::out_cnt_t'(fir_pkg::OUT_CREDITS);
        end else begin
            case ({pop_o, out_credit_i})
                2'b10: out_credits_q <= out_credits_q - 1'b1;
                2'b01: out_credits_q <= out_credits_q + 1'b1;
                default: out_credits_q <= out_credits_q;
            endcase
        end
    end

    // sink never returns more than it was given
    credit_bound_a: assert property (@(posedge clk) disable iff (rst)
        out_credits_q <= fir_pkg::out_cnt_t'(fir_pkg::OUT_CREDITS));

    // no result can pop while a fill credit is still pending
    credit_merge_a: assert property (@(posedge clk) disable iff (rst)
        !(fill_credit_q && pop_o));

endmodule

/* logic/fir_out_queue.sv */
`timescale 1ns/10ps

module fir_out_queue (
    input  logic                clk,
    input  logic                rst,
    input  fir_pkg::fir_beat_t  push_i,
    input  logic                pop_i,
    output logic                head_valid_o,
    output fir_pkg::sample_t    head_o
);

    fir_pkg::sample_t mem_q [fir_pkg::QUEUE_DEPTH];
    fir_pkg::qptr_t wr_ptr_q;
    fir_pkg::qptr_t rd_ptr_q;
    fir_pkg::qcnt_t count_q;
    logic full;

    assign full = count_q == fir_pkg::qcnt_t'(fir_pkg::QUEUE_DEPTH);
    assign head_valid_o = count_q != '0;
    assign head_o = mem_q[rd_ptr_q];

    always_ff @(posedge clk) begin
        if (push_i.valid) begin
            mem_q[wr_ptr_q] <= push_i.data;
        end
    end

    // pointers wrap on their own, depth is a power of two
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q <= '0;
        end else begin
            if (push_i.valid) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (pop_i) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            case ({push_i.valid, pop_i})
                2'b10: count_q <= count_q + 1'b1;
                2'b01: count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    // input credits bound the samples in flight to the depth
    no_overflow_a: assert property (@(posedge clk) disable iff (rst)
        push_i.valid |-> !full);

    no_underflow_a: assert property (@(posedge clk) disable iff (rst)
        pop_i |-> head_valid_o);

endmodule

/* logic/fir_filter_top.sv */
`timescale 1ns/10ps

module fir_filter_top (
    input  logic              clk,
    input  logic              rst,
    input  logic              in_valid_i,
    input  fir_pkg::sample_t  in_data_i,
    output logic              in_credit_o,
    output logic              out_valid_o,
    output fir_pkg::sample_t  out_data_o,
    input  logic              out_credit_i
);

    logic shift;
    logic mac_valid;
    logic head_valid;
    fir_pkg::tap_vec_t taps;
    fir_pkg::fir_beat_t beat;

    fir_ctrl fir_ctrl_inst (
        .clk          (clk),
        .rst          (rst),
        .in_valid_i   (in_valid_i),
        .out_credit_i (out_credit_i),
        .head_valid_i (head_valid),
        .shift_o      (shift),
        .mac_valid_o  (mac_valid),
        .pop_o        (out_valid_o),
        .in_credit_o  (in_credit_o)
    );

    fir_tap_line fir_tap_line_inst (
        .clk      (clk),
        .rst      (rst),
        .shift_i  (shift),
        .sample_i (in_data_i),
        .taps_o   (taps)
    );

    fir_mac fir_mac_inst (
        .clk     (clk),
        .rst     (rst),
        .valid_i (mac_valid),
        .taps_i  (taps),
        .beat_o  (beat)
    );

    // a pop is the output strobe
    fir_out_queue fir_out_queue_inst (
        .clk          (clk),
        .rst          (rst),
        .push_i       (beat),
        .pop_i        (out_valid_o),
        .head_valid_o (head_valid),
        .head_o       (out_data_o)
    );

endmodule

/* tb/fir_filter_tests.svh */
task automatic idle_after_reset();
    apply_reset();
    repeat (8) begin
        tick();
        check_bit("out_valid_o", 1'b0, out_valid_o);
        check_bit("in_credit_o", 1'b0, in_credit_o);
    end
endtask

// fill samples hand their credit back but give no result
task automatic fill_without_results();
    apply_reset();
    repeat (fir_pkg::TAPS - 1) send_sample(fir_pkg::sample_t'($random(seed)));
    repeat (4) tick();
    check_count("results after fill", 0, results);
    check_count("source credits after fill", fir_pkg::IN_CREDITS, src_credits);
endtask

task automatic impulse_response();
    apply_reset();
    sink_release = 1'b1;
    repeat (fir_pkg::TAPS - 1) send_sample('0);
    send_sample(16'sh4000);
    repeat (fir_pkg::TAPS - 1) send_sample('0);
    drain_results();
    check_count("impulse results", fir_pkg::TAPS, results);
endtask

task automatic random_stream();
    apply_reset();
    sink_release = 1'b1;
    repeat (200) send_sample(fir_pkg::sample_t'($random(seed)));
    drain_results();
    check_count("stream results", 200 - (fir_pkg::TAPS - 1), results);
endtask

task automatic back_pressure();
    int sent;
    apply_reset();
    repeat (fir_pkg::TAPS - 1) send_sample(fir_pkg::sample_t'($random(seed)));
    sent = 0;
    // sink keeps every credit so the source runs dry
    while (src_credits > 0 && sent < 20) begin
        send_sample(fir_pkg::sample_t'($random(seed)));
        sent++;
    end
    repeat (20) tick();
    check_count("results while stalled", fir_pkg::OUT_CREDITS, results);
    check_count("source credits while stalled", 0, src_credits);
    check_count("samples sent before the stall",
        fir_pkg::IN_CREDITS + fir_pkg::OUT_CREDITS, sent);
    sink_release = 1'b1;
    repeat (6) send_sample(fir_pkg::sample_t'($random(seed)));
    drain_results();
    check_count("results after release", sent + 6, results);
endtask

task automatic burst_throughput();
    apply_reset();
    sink_release = 1'b1;
    repeat (fir_pkg::TAPS - 1 + 40) send_sample(fir_pkg::sample_t'($random(seed)));
    drain_results();
    check_count("burst results", 40, results);
    if (max_in_flight < 2) begin
        $display("burst never had more than one sample in flight");
        stop_on_error();
    end
endtask

/* tb/fir_filter_tb.sv */
`timescale 1ns/10ps

module fir_filter_tb;

    localparam int CLK_PERIOD = 40;
    localparam int RESET_CYCLES = 4;
    localparam int NUM_TESTS = 6;
    // samples sent over all tests, rounded up
    localparam int TOTAL_SAMPLES = 420;

    logic clk = 1'b0;
    logic rst;
    logic in_valid_i;
    fir_pkg::sample_t in_data_i;
    logic in_credit_o;
    logic out_valid_o;
    fir_pkg::sample_t out_data_o;
    logic out_credit_i;

    int seed = 32'h28fa_ea03;
    int src_credits;
    int sink_owed;
    int results;
    int max_in_flight;
    logic sink_release;
    // accepted samples, newest at the back
    fir_pkg::sample_t hist_q[$];
    fir_pkg::sample_t exp_q[$];

    always #(CLK_PERIOD / 2) clk = ~clk;

    fir_filter_top fir_filter_top_inst (.*);

    task automatic stop_on_error();
        $display("SOME TESTS FAILED");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_sample(string name, fir_pkg::sample_t exp, fir_pkg::sample_t act);
        if (act !== exp) begin
            $display("FAILED t=%0t %s expected %0d got %0d", $time, name, exp, act);
            stop_on_error();
        end
    endtask

    task automatic check_bit(string name, logic exp, logic act);
        if (act !== exp) begin
            $display("FAILED t=%0t %s expected %b got %b", $time, name, exp, act);
            stop_on_error();
        end
    endtask

    task automatic check_count(string what, int exp, int act);
        if (act != exp) begin
            $display("FAILED t=%0t %s expected %0d got %0d", $time, what, exp, act);
            stop_on_error();
        end
    endtask

    function automatic fir_pkg::sample_t reference_result();
        longint sum;
        longint shifted;
        sum = 0;
        for (int j = 0; j < fir_pkg::HALF_TAPS; j++) begin
            sum += longint'(fir_pkg::FIR_COEF[j])
                * (longint'(hist_q[fir_pkg::TAPS-1-j]) + longint'(hist_q[j]));
        end
        // negative sums gain one after the shift
        shifted = (sum >>> fir_pkg::ZOOM) + ((sum < 0) ? 1 : 0);
        return shifted[fir_pkg::SAMPLE_W-1:0];
    endfunction

    // outputs settle after the rising edge, so look at them on the falling one
    task automatic tick();
        @(negedge clk);
        if (!rst && in_credit_o)
            src_credits++;
        if (!rst && out_valid_o) begin
            if (exp_q.size() == 0) begin
                $display("a result appeared at %0t with none expected", $time);
                stop_on_error();
            end
            check_sample("out_data_o", exp_q.pop_front(), out_data_o);
            results++;
            sink_owed++;
        end
        // sink hands back one held credit per cycle when allowed
        out_credit_i = sink_release && sink_owed > 0;
        if (out_credit_i)
            sink_owed--;
    endtask

    task automatic send_sample(fir_pkg::sample_t x);
        while (src_credits == 0)
            tick();
        in_valid_i = 1'b1;
        in_data_i = x;
        src_credits--;
        if (fir_pkg::IN_CREDITS - src_credits > max_in_flight)
            max_in_flight = fir_pkg::IN_CREDITS - src_credits;
        hist_q.push_back(x);
        if (hist_q.size() > fir_pkg::TAPS)
            void'(hist_q.pop_front());
        if (hist_q.size() == fir_pkg::TAPS)
            exp_q.push_back(reference_result());
        tick();
        in_valid_i = 1'b0;
    endtask

    task automatic apply_reset();
        rst = 1'b1;
        in_valid_i = 1'b0;
        in_data_i = '0;
        out_credit_i = 1'b0;
        sink_release = 1'b0;
        sink_owed = 0;
        repeat (RESET_CYCLES) tick();
        rst = 1'b0;
        src_credits = fir_pkg::IN_CREDITS;
        results = 0;
        max_in_flight = 0;
        hist_q.delete();
        exp_q.delete();
    endtask

    task automatic drain_results();
        while (exp_q.size() != 0 || src_credits != fir_pkg::IN_CREDITS)
            tick();
    endtask

    `include "fir_filter_tests.svh"

    initial begin
        #(CLK_PERIOD * (2 * TOTAL_SAMPLES * 10 + NUM_TESTS * RESET_CYCLES));
        $display("watchdog timeout, the tests did not finish in time");
        stop_on_error();
    end

    initial begin
        idle_after_reset();
        fill_without_results();
        impulse_response();
        random_stream();
        back_pressure();
        burst_throughput();
        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

/* fir_filter.f */
logic/fir_pkg.sv
logic/fir_tap_line.sv
logic/fir_mac.sv
logic/fir_ctrl.sv
logic/fir_out_queue.sv
logic/fir_filter_top.sv
+incdir+tb
tb/fir_filter_tb.sv

/* run_sim.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module fir_filter_tb \
    -Mdir obj_dir -f fir_filter.f > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "verilator build failed"
    exit 1
fi

./obj_dir/Vfir_filter_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "ALL TESTS PASSED" sim.log; then
    exit 0
fi
echo "pass message not found in sim.log"
exit 1
